// ==== sim.f ====
logic/tube_pkg.sv
logic/refresh_tick.sv
logic/digit_converter.sv
logic/digit_scanner.sv
logic/segment_encoder.sv
logic/seven_seg_unit.sv
verification/seven_seg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the seven-segment testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module seven_seg_tb -Mdir obj_dir -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vseven_seg_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== verification/seven_seg_tb.sv ====
module seven_seg_tb;

    import tube_pkg::*;

    localparam int DELAY_PERIOD    = 4;
    localparam int NUM_CASES       = 20;
    localparam int WATCHDOG_CYCLES = NUM_CASES * (ISA_WIDTH + 3 + 24 * DELAY_PERIOD) + 200;

    logic                 clk_tube;
    logic                 rst_n;
    logic [ISA_WIDTH-1:0] display_value;
    logic                 switch_enable;
    logic                 input_enable;
    seg_t                 seg_tube;
    enable_t              seg_enable;

    integer                seed;
    logic [NUM_DIGITS-1:0] exp_lit;
    seg_t                  exp_glyph [NUM_DIGITS];

    // active-low patterns for 0 to 9 with segment a in the lsb
    seg_t glyph_tab [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                             7'h12, 7'h02, 7'h78, 7'h00, 7'h10};

    seven_seg_unit #(
        .DELAY_PERIOD (DELAY_PERIOD)
    ) seven_seg_unit_i (
        .clk_tube      (clk_tube),
        .rst_n         (rst_n),
        .display_value (display_value),
        .switch_enable (switch_enable),
        .input_enable  (input_enable),
        .seg_tube      (seg_tube),
        .seg_enable    (seg_enable)
    );

    initial begin
        clk_tube = 1'b0;
        forever #10 clk_tube = ~clk_tube;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_tube);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1);
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %b, actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_enable(input string name, input enable_t exp, input enable_t act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %b, actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // expected picture per position, straight from the display rules
    task automatic build_expected(input logic [ISA_WIDTH-1:0] value, input logic bin,
                                  input logic en);
        logic [ISA_WIDTH-1:0] rest;
        logic [ISA_WIDTH-1:0] scale;
        digit_t               d;
        logic                 lit_i;
        rest  = value % 32'd100000000;
        scale = 32'd1;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (bin) begin
                d     = digit_t'((value >> i) & 32'd1);
                lit_i = en;
            end else begin
                d     = digit_t'((rest / scale) % 32'd10);
                lit_i = en && ((i == 0) || (rest >= scale)); // leading zeros dark
            end
            exp_lit[pos_t'(i)]   = lit_i;
            exp_glyph[pos_t'(i)] = glyph_tab[d];
            scale                = scale * 32'd10;
        end
    endtask

    task automatic record_sweep();
        logic [NUM_DIGITS-1:0] seen;
        logic                  found;
        pos_t                  p;
        enable_t               exp_en;
        seen = '0;
        repeat (16 * DELAY_PERIOD) begin
            @(negedge clk_tube);
            found = 1'b0;
            p     = '0;
            for (int i = NUM_DIGITS - 1; i >= 0; i--) begin
                if (!seg_enable[pos_t'(i)]) begin
                    p     = pos_t'(i);
                    found = 1'b1;
                end
            end
            if (found) begin
                exp_en = '1;
                if (exp_lit[p]) begin
                    exp_en[p] = 1'b0;
                end
                check_enable("seg_enable", exp_en, seg_enable); // also catches two low bits
                check_seg("seg_tube", exp_glyph[p], seg_tube);
                seen[p] = 1'b1;
            end else begin
                check_seg("seg_tube", SEG_BLANK, seg_tube);
            end
        end
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (exp_lit[pos_t'(i)] && !seen[pos_t'(i)]) begin
                $display("position %0d should have lit but stayed dark for the whole sweep", i);
                abort_run();
            end
        end
    endtask

    task automatic run_case(input logic [ISA_WIDTH-1:0] value, input logic bin,
                            input logic en);
        @(posedge clk_tube);
        display_value <= value;
        switch_enable <= bin;
        input_enable  <= en;
        build_expected(value, bin, en);
        repeat (ISA_WIDTH + 3 + 8 * DELAY_PERIOD) @(posedge clk_tube); // settle plus one scan
        record_sweep();
    endtask

    task automatic test_reset_zero();
        run_case(32'd0, 1'b0, 1'b1);
    endtask

    task automatic test_decimal_values();
        run_case(32'd12345678, 1'b0, 1'b1);
        run_case(32'd90000001, 1'b0, 1'b1);
        run_case(32'd7, 1'b0, 1'b1);
        run_case(32'd100000123, 1'b0, 1'b1); // wraps past eight digits
    endtask

    task automatic test_binary_mode();
        logic [ISA_WIDTH-1:0] rnd;
        rnd = $random(seed);
        run_case(32'h0000_00A5, 1'b1, 1'b1);
        run_case(rnd, 1'b1, 1'b1);
    endtask

    task automatic test_display_enable();
        run_case(32'd4321, 1'b0, 1'b0);
        run_case(32'd4321, 1'b0, 1'b1);
    endtask

    task automatic test_change_during_conversion();
        @(posedge clk_tube);
        display_value <= 32'd12345678;
        switch_enable <= 1'b0;
        repeat (6) @(posedge clk_tube);
        display_value <= 32'd87654321; // lands while the first value is converting
        repeat (ISA_WIDTH + 3) @(posedge clk_tube);
        run_case(32'd87654321, 1'b0, 1'b1);
    endtask

    task automatic test_random_values();
        integer rnd_value;
        integer rnd_mode;
        for (int n = 0; n < 10; n++) begin
            rnd_value = $random(seed);
            rnd_mode  = $random(seed);
            run_case(rnd_value, rnd_mode[0], 1'b1);
        end
    endtask

    initial begin
        seed          = 88755;
        rst_n         <= 1'b0;
        display_value <= '0;
        switch_enable <= 1'b0;
        input_enable  <= 1'b0;
        repeat (2) @(posedge clk_tube);
        rst_n <= 1'b1;

        test_reset_zero();
        test_decimal_values();
        test_binary_mode();
        test_display_enable();
        test_change_during_conversion();
        test_random_values();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== logic/seven_seg_unit.sv ====
module seven_seg_unit #(
    parameter int DELAY_PERIOD = 100000 // 1 ms scan step at 100 MHz
) (
    input  logic                           clk_tube,
    input  logic                           rst_n,
    input  logic [tube_pkg::ISA_WIDTH-1:0] display_value,
    input  logic                           switch_enable,
    input  logic                           input_enable,
    output tube_pkg::seg_t                 seg_tube,
    output tube_pkg::enable_t              seg_enable
);

    import tube_pkg::*;

    logic   scan_tick;
    frame_u frame;
    logic   frame_bin;
    logic   frame_load;
    digit_t digit;
    pos_t   position;
    logic   lit;
    logic   step;

    refresh_tick #(
        .DELAY_PERIOD (DELAY_PERIOD)
    ) refresh_tick_i (
        .clk_tube  (clk_tube),
        .rst_n     (rst_n),
        .scan_tick (scan_tick)
    );

    digit_converter digit_converter_i (
        .clk_tube      (clk_tube),
        .rst_n         (rst_n),
        .display_value (display_value),
        .switch_enable (switch_enable),
        .frame         (frame),
        .frame_bin     (frame_bin),
        .frame_load    (frame_load)
    );

    digit_scanner digit_scanner_i (
        .clk_tube     (clk_tube),
        .rst_n        (rst_n),
        .scan_tick    (scan_tick),
        .input_enable (input_enable),
        .frame        (frame),
        .frame_bin    (frame_bin),
        .frame_load   (frame_load),
        .digit        (digit),
        .position     (position),
        .lit          (lit),
        .step         (step)
    );

    segment_encoder segment_encoder_i (
        .clk_tube   (clk_tube),
        .rst_n      (rst_n),
        .digit      (digit),
        .position   (position),
        .lit        (lit),
        .step       (step),
        .seg_tube   (seg_tube),
        .seg_enable (seg_enable)
    );

endmodule

// ==== logic/segment_encoder.sv ====
module segment_encoder (
    input  logic              clk_tube,
    input  logic              rst_n,
    input  tube_pkg::digit_t  digit,
    input  tube_pkg::pos_t    position,
    input  logic              lit,
    input  logic              step,
    output tube_pkg::seg_t    seg_tube,
    output tube_pkg::enable_t seg_enable
);

    import tube_pkg::*;

    seg_t    glyph;
    enable_t pos_mask;

    always_comb begin
        case (digit)
            4'd0:    glyph = 7'b100_0000;
            4'd1:    glyph = 7'b111_1001;
            4'd2:    glyph = 7'b010_0100;
            4'd3:    glyph = 7'b011_0000;
            4'd4:    glyph = 7'b001_1001;
            4'd5:    glyph = 7'b001_0010;
            4'd6:    glyph = 7'b000_0010;
            4'd7:    glyph = 7'b111_1000;
            4'd8:    glyph = 7'b000_0000;
            4'd9:    glyph = 7'b001_0000;
            default: glyph = SEG_BLANK; // no hex digits on this display
        endcase
    end

    always_comb begin
        pos_mask           = '1;
        pos_mask[position] = 1'b0; // only the scanned tube pulled low
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            seg_tube   <= SEG_BLANK;
            seg_enable <= '1;
        end else if (step) begin
            if (lit) begin
                seg_tube   <= glyph;
                seg_enable <= pos_mask;
            end else begin
                seg_tube   <= SEG_BLANK;
                seg_enable <= '1;
            end
        end
    end

endmodule

// ==== logic/digit_scanner.sv ====
module digit_scanner (
    input  logic              clk_tube,
    input  logic              rst_n,
    input  logic              scan_tick,
    input  logic              input_enable,
    input  tube_pkg::frame_u  frame,
    input  logic              frame_bin,
    input  logic              frame_load,
    output tube_pkg::digit_t  digit,
    output tube_pkg::pos_t    position,
    output logic              lit,
    output logic              step
);

    import tube_pkg::*;

    frame_u                held_frame;
    logic                  held_bin;
    pos_t                  next_pos;
    digit_t                next_digit;
    logic                  next_lit;
    logic [NUM_DIGITS-1:0] lead_nz; // bit i set when digit i or a higher one is nonzero

    always_comb begin : leading_scan
        logic seen;
        seen = 1'b0;
        for (int i = NUM_DIGITS - 1; i >= 0; i--) begin
            seen       = seen | (held_frame.bcd[i] != 4'd0);
            lead_nz[i] = seen;
        end
    end

    assign next_pos = position + 3'd1; // wraps from 7 to 0

    always_comb begin
        if (held_bin) begin
            next_digit = {3'b000, held_frame.raw[next_pos]};
        end else begin
            next_digit = held_frame.bcd[next_pos];
        end
    end

    // rightmost tube stays lit even for an all-zero value
    assign next_lit = input_enable && (held_bin || (next_pos == 3'd0) || lead_nz[next_pos]);

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            held_frame <= '0;
            held_bin   <= 1'b0;
            position   <= '0;
            lit        <= 1'b0;
            step       <= 1'b0;
        end else begin
            if (frame_load) begin
                held_frame <= frame;
                held_bin   <= frame_bin;
            end
            step <= scan_tick;
            if (scan_tick) begin
                position <= next_pos;
                lit      <= next_lit;
            end
        end
    end

    always_ff @(posedge clk_tube) begin
        if (scan_tick) begin
            digit <= next_digit;
        end
    end

endmodule

// ==== logic/digit_converter.sv ====
module digit_converter (
    input  logic                           clk_tube,
    input  logic                           rst_n,
    input  logic [tube_pkg::ISA_WIDTH-1:0] display_value,
    input  logic                           switch_enable,
    output tube_pkg::frame_u               frame,
    output logic                           frame_bin,
    output logic                           frame_load
);

    import tube_pkg::*;

    localparam int BCD_WIDTH = 40; // ten digits cover any 32-bit value
    localparam int CNT_WIDTH = $clog2(ISA_WIDTH + 1);

    logic [ISA_WIDTH-1:0] snap_value;
    logic                 snap_bin;
    logic                 busy;
    logic [CNT_WIDTH-1:0] bit_cnt;
    logic [ISA_WIDTH-1:0] shift_reg;
    logic [BCD_WIDTH-1:0] bcd_acc;
    logic [BCD_WIDTH-1:0] bcd_adj;
    logic                 start;
    logic                 done;

    // add three to every nibble that has reached five
    function automatic logic [BCD_WIDTH-1:0] add_three(input logic [BCD_WIDTH-1:0] acc);
        logic [BCD_WIDTH-1:0] result;
        result = acc;
        for (int i = 0; i < BCD_WIDTH / 4; i++) begin
            if (result[4*i +: 4] >= 4'd5) begin
                result[4*i +: 4] = result[4*i +: 4] + 4'd3;
            end
        end
        return result;
    endfunction

    assign bcd_adj = add_three(bcd_acc);

    // retried every idle cycle, so a change seen while busy is picked up later
    assign start = !busy && ((display_value != snap_value) || (switch_enable != snap_bin));
    assign done  = busy && (bit_cnt == CNT_WIDTH'(ISA_WIDTH));

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            snap_value <= '0;
            snap_bin   <= 1'b0;
            busy       <= 1'b0;
            bit_cnt    <= '0;
            frame_load <= 1'b0;
            frame_bin  <= 1'b0;
        end else begin
            frame_load <= 1'b0;
            if (start) begin
                snap_value <= display_value;
                snap_bin   <= switch_enable;
                bit_cnt    <= '0;
                busy       <= !switch_enable; // binary frames need no conversion
                if (switch_enable) begin
                    frame_load <= 1'b1;
                    frame_bin  <= 1'b1;
                end
            end else if (done) begin
                busy       <= 1'b0;
                frame_load <= 1'b1;
                frame_bin  <= 1'b0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_tube) begin
        if (start) begin
            shift_reg <= display_value;
            bcd_acc   <= '0;
            if (switch_enable) begin
                frame.raw <= display_value;
            end
        end else if (done) begin
            frame.bcd <= bcd_acc[NUM_DIGITS*4-1:0]; // low eight digits, i.e. mod 10^8
        end else if (busy) begin
            bcd_acc   <= {bcd_adj[BCD_WIDTH-2:0], shift_reg[ISA_WIDTH-1]}; // msb first
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

// ==== logic/refresh_tick.sv ====
module refresh_tick #(
    parameter int DELAY_PERIOD = 100000
) (
    input  logic clk_tube,
    input  logic rst_n,
    output logic scan_tick
);

    localparam int CNT_WIDTH = (DELAY_PERIOD > 1) ? $clog2(DELAY_PERIOD) : 1;

    logic [CNT_WIDTH-1:0] tick_cnt;
    logic                 wrap;

    assign wrap = (tick_cnt == CNT_WIDTH'(DELAY_PERIOD - 1));

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt  <= '0;
            scan_tick <= 1'b0;
        end else begin
            if (wrap) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            scan_tick <= wrap; // one cycle wide, once per period
        end
    end

endmodule

// ==== logic/tube_pkg.sv ====
package tube_pkg;

    // width of the value shown on the tubes
    localparam int ISA_WIDTH  = 32;

    // number of tube positions, position 0 is the rightmost one
    localparam int NUM_DIGITS = 8;

    // one decimal digit as it travels down the pipeline
    typedef logic [3:0] digit_t;

    // scan position
    typedef logic [2:0] pos_t;

    // segment pattern, active low, a at bit 0 up to g at bit 6
    typedef logic [6:0] seg_t;

    // position enable, active low, bit i drives position i
    typedef logic [NUM_DIGITS-1:0] enable_t;

    // all segments dark
    localparam seg_t SEG_BLANK = 7'b111_1111;

    // one displayed frame
    // bcd view: digit i goes to position i (decimal mode)
    // raw view: bit i goes to position i (binary mode)
    typedef union packed {
        digit_t [NUM_DIGITS-1:0] bcd;
        logic   [ISA_WIDTH-1:0]  raw;
    } frame_u;

endpackage
